/* src.f */
hdl/bus_pkg.sv
hdl/bus_mux.sv
hdl/bus_decoder.sv
hdl/bus_memory.sv
hdl/bus_status_regs.sv
hdl/bus_subsystem.sv
testbench/bus_subsystem_assertions.sv
testbench/tb_bus_subsystem.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -f src.f --top-module tb_bus_subsystem -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^Everything OK$" \
	&& echo "run.sh: PASS" \
	|| { echo "run.sh: FAIL"; exit 1; }

/* testbench/tb_bus_subsystem.sv */
// ============================================================
// Bus subsystem directed testbench
// ============================================================

`timescale 1ns/1ns

module tb_bus_subsystem import bus_pkg::*; ();

	logic clock;
	logic reset;
	logic pa_request;
	bus_addr_t pa_address;
	logic pa_ready;
	bus_data_t pa_rdata;
	logic pb_request;
	bus_req_t pb_cmd;
	logic pb_ready;
	bus_data_t pb_rdata;
	logic fault;

	// Reference model state
	bus_data_t ref_mem [MEM_WORDS];
	bus_data_t ref_reads;
	bus_data_t ref_writes;
	bus_data_t ref_scratch;
	logic ref_fault;
	int value_errors;
	int protocol_errors;

	bus_subsystem u_bus_subsystem (
		.i_clock(clock),
		.i_reset(reset),
		.i_pa_request(pa_request),
		.i_pa_address(pa_address),
		.o_pa_ready(pa_ready),
		.o_pa_rdata(pa_rdata),
		.i_pb_request(pb_request),
		.i_pb_cmd(pb_cmd),
		.o_pb_ready(pb_ready),
		.o_pb_rdata(pb_rdata),
		.o_fault(fault)
	);

	always #5 clock = ~clock;

	// ============================================================
	// Predicts the rdata of one access and updates the model
	function automatic bus_data_t predict(input logic rw, input bus_addr_t address,
		input bus_data_t wdata);
		bus_data_t result;
		int word;
		logic [3:0] offset;
		result = '0;
		word = int'(address[27:2]);
		offset = {address[3:2], 2'b00};
		if (address[31:28] == MEM_BASE[31:28] && word < MEM_WORDS) begin
			if (rw)
				ref_mem[word] = wdata;
			result = rw ? wdata : ref_mem[word];
		end else if (address[31:28] == STATUS_BASE[31:28]) begin
			if (offset == STATUS_READS[3:0])
				result = ref_reads;
			else if (offset == STATUS_WRITES[3:0])
				result = ref_writes;
			else if (offset == STATUS_SCRATCH[3:0])
				result = ref_scratch;
			else
				result = {31'b0, ref_fault};
			if (rw && offset == STATUS_SCRATCH[3:0])
				ref_scratch = wdata;
			if (rw && offset == STATUS_FAULT[3:0] && wdata[0])
				ref_fault = 1'b0;
		end else begin
			ref_fault = 1'b1;
		end
		if (rw)
			ref_writes = ref_writes + 1;
		else
			ref_reads = ref_reads + 1;
		return result;
	endfunction

	task automatic check_value(input string name, input bus_data_t expected,
		input bus_data_t actual);
		assert (actual == expected) else begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			value_errors++;
		end
	endtask

	// One access on one port while the mux is idle
	task automatic run_access(input logic use_b, input logic rw, input bus_addr_t address,
		input bus_data_t wdata, input string name, output bus_data_t rdata);
		int cycles;
		logic seen;
		cycles = 0;
		seen = 1'b0;
		rdata = '0;
		if (use_b) begin
			pb_request = 1'b1;
			pb_cmd.rw = rw;
			pb_cmd.address = address;
			pb_cmd.wdata = wdata;
		end else begin
			pa_request = 1'b1;
			pa_address = address;
		end
		while (!seen && cycles < 20) begin
			@(posedge clock);
			#1;
			cycles++;
			if (use_b ? pb_ready : pa_ready) begin
				seen = 1'b1;
				rdata = use_b ? pb_rdata : pa_rdata;
			end
		end
		pa_request = 1'b0;
		pb_request = 1'b0;
		assert (seen) else begin
			$display("Timeout in %s, no ready within 20 cycles", name);
			protocol_errors++;
		end
		if (seen)
			check_value({name, " latency"}, 32'd3, bus_data_t'(cycles));
		@(posedge clock);
		#1;
	endtask

	task automatic do_read(input logic use_b, input bus_addr_t address, input string name);
		bus_data_t expected;
		bus_data_t rdata;
		expected = predict(1'b0, address, '0);
		run_access(use_b, 1'b0, address, '0, name, rdata);
		check_value(name, expected, rdata);
	endtask

	task automatic do_write(input bus_addr_t address, input bus_data_t wdata,
		input string name);
		bus_data_t ignored;
		ignored = predict(1'b1, address, wdata);
		run_access(1'b1, 1'b1, address, wdata, name, ignored);
	endtask

	// Both ports request at the same edge and port B goes first
	task automatic do_pair(input bus_addr_t a_address, input logic b_rw,
		input bus_addr_t b_address, input bus_data_t b_wdata, input string name);
		bus_data_t expect_a;
		bus_data_t expect_b;
		bus_data_t got_a;
		bus_data_t got_b;
		int cycles;
		int a_cycle;
		int b_cycle;
		expect_b = predict(b_rw, b_address, b_wdata);
		expect_a = predict(1'b0, a_address, '0);
		got_a = '0;
		got_b = '0;
		cycles = 0;
		a_cycle = 0;
		b_cycle = 0;
		pa_request = 1'b1;
		pa_address = a_address;
		pb_request = 1'b1;
		pb_cmd.rw = b_rw;
		pb_cmd.address = b_address;
		pb_cmd.wdata = b_wdata;
		while ((a_cycle == 0 || b_cycle == 0) && cycles < 20) begin
			@(posedge clock);
			#1;
			cycles++;
			if (pb_ready && b_cycle == 0) begin
				b_cycle = cycles;
				got_b = pb_rdata;
				pb_request = 1'b0;
			end
			if (pa_ready && a_cycle == 0) begin
				a_cycle = cycles;
				got_a = pa_rdata;
				pa_request = 1'b0;
			end
		end
		pa_request = 1'b0;
		pb_request = 1'b0;
		assert (a_cycle != 0 && b_cycle != 0) else begin
			$display("Timeout in %s, a port never saw ready", name);
			protocol_errors++;
		end
		check_value({name, " B latency"}, 32'd3, bus_data_t'(b_cycle));
		check_value({name, " A latency"}, 32'd6, bus_data_t'(a_cycle));
		check_value({name, " B data"}, expect_b, got_b);
		check_value({name, " A data"}, expect_a, got_a);
		@(posedge clock);
		#1;
	endtask

	task automatic check_status(input string name);
		do_read(1'b1, STATUS_BASE + STATUS_READS, {name, " reads"});
		do_read(1'b0, STATUS_BASE + STATUS_WRITES, {name, " writes"});
		do_read(1'b1, STATUS_BASE + STATUS_SCRATCH, {name, " scratch"});
		check_value({name, " o_fault"}, {31'b0, ref_fault}, {31'b0, fault});
	endtask

	// ============================================================
	// Test sequence
	initial begin
		int seed_value;
		int word;
		bus_addr_t address;
		seed_value = $urandom(32'hb024);
		clock = 1'b0;
		reset = 1'b1;
		pa_request = 1'b0;
		pa_address = '0;
		pb_request = 1'b0;
		pb_cmd = '0;
		value_errors = 0;
		protocol_errors = 0;
		for (int i = 0; i < MEM_WORDS; i++)
			ref_mem[i] = '0;
		ref_reads = '0;
		ref_writes = '0;
		ref_scratch = '0;
		ref_fault = 1'b0;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;

		// Reset state
		check_value("reset pa_ready", 32'd0, {31'b0, pa_ready});
		check_value("reset pb_ready", 32'd0, {31'b0, pb_ready});
		check_status("reset");

		// Write then read back on the other port
		do_write(32'h0000_0040, 32'hcafe_0123, "write B");
		do_read(1'b0, 32'h0000_0040, "read A");

		// Contention
		do_pair(32'h0000_0080, 1'b1, 32'h0000_0080, 32'h1234_5678, "pair write");
		do_pair(32'h0000_0040, 1'b0, 32'h0000_0080, '0, "pair read");

		// Counters and scratch
		do_write(STATUS_BASE + STATUS_SCRATCH, 32'h5a5a_a5a5, "scratch write");
		do_write(STATUS_BASE + STATUS_READS, 32'hffff_ffff, "counter write");
		check_status("mixed");

		// Unmapped accesses and fault clear
		do_read(1'b0, 32'h2000_0000, "unmapped region");
		do_read(1'b1, 32'h0000_0400, "beyond RAM");
		do_read(1'b1, 32'h0000_0040, "after fault");
		do_read(1'b0, STATUS_BASE + STATUS_FAULT, "fault flag");
		check_status("fault set");
		do_write(STATUS_BASE + STATUS_FAULT, 32'h1, "fault clear");
		check_status("fault cleared");

		// Random traffic over the whole RAM
		for (int i = 0; i < 40; i++) begin
			word = int'($urandom % MEM_WORDS);
			address = bus_addr_t'(word) << 2;
			do_write(address, $urandom, "random write");
			do_read(($urandom % 2) == 1, address, "random read");
		end
		check_status("final");

		$display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* testbench/bus_subsystem_assertions.sv */
// ============================================================
// Bus multiplexer protocol checks
// ============================================================

`timescale 1ns/1ns

module bus_subsystem_assertions import bus_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic o_bus_request,
	input bus_rsp_t i_bus_rsp,
	input logic o_pa_ready,
	input logic o_pb_ready
);

	logic in_flight;

	// Strobe sent, reply not yet seen
	always_ff @(posedge i_clock) begin
		if (i_reset)
			in_flight <= 1'b0;
		else if (o_bus_request)
			in_flight <= 1'b1;
		else if (i_bus_rsp.ready)
			in_flight <= 1'b0;
	end

	a_strobe_single: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request |=> !o_bus_request)
		else $error("Bus strobe stayed high for more than one cycle");

	a_no_overlap: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request |-> !in_flight)
		else $error("New bus strobe issued before the previous reply");

	a_ready_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
		!(o_pa_ready && o_pb_ready))
		else $error("Both port ready signals high together");

	a_ready_latency: assert property (@(posedge i_clock) disable iff (i_reset)
		o_bus_request |-> ##2 (o_pa_ready || o_pb_ready))
		else $error("Port ready did not follow the strobe by two cycles");

endmodule

bind bus_mux bus_subsystem_assertions u_bus_subsystem_assertions (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.o_bus_request(o_bus_request),
	.i_bus_rsp(i_bus_rsp),
	.o_pa_ready(o_pa_ready),
	.o_pb_ready(o_pb_ready)
);

/* hdl/bus_subsystem.sv */
// ============================================================
// Bus subsystem top level
// ============================================================

`timescale 1ns/1ns

module bus_subsystem import bus_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	input logic i_pa_request,
	input bus_addr_t i_pa_address,
	output logic o_pa_ready,
	output bus_data_t o_pa_rdata,

	input logic i_pb_request,
	input bus_req_t i_pb_cmd,
	output logic o_pb_ready,
	output bus_data_t o_pb_rdata,

	output logic o_fault
);

	// Shared bus
	logic bus_request;
	bus_req_t bus_cmd;
	bus_rsp_t bus_rsp;

	// Target side
	logic mem_request;
	logic status_request;
	bus_req_t target_cmd;
	bus_rsp_t mem_rsp;
	bus_rsp_t status_rsp;
	bus_event_t bus_event;

	// ============================================================
	// Multiplexer
	bus_mux u_bus_mux (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pa_request(i_pa_request),
		.i_pa_address(i_pa_address),
		.o_pa_ready(o_pa_ready),
		.o_pa_rdata(o_pa_rdata),
		.i_pb_request(i_pb_request),
		.i_pb_cmd(i_pb_cmd),
		.o_pb_ready(o_pb_ready),
		.o_pb_rdata(o_pb_rdata),
		.o_bus_request(bus_request),
		.o_bus_cmd(bus_cmd),
		.i_bus_rsp(bus_rsp)
	);

	// ============================================================
	// Decoder and targets
	bus_decoder u_bus_decoder (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus_request(bus_request),
		.i_bus_cmd(bus_cmd),
		.o_bus_rsp(bus_rsp),
		.o_mem_request(mem_request),
		.o_status_request(status_request),
		.o_cmd(target_cmd),
		.i_mem_rsp(mem_rsp),
		.i_status_rsp(status_rsp),
		.o_event(bus_event)
	);

	bus_memory u_bus_memory (
		.i_clock(i_clock),
		.i_request(mem_request),
		.i_cmd(target_cmd),
		.o_rsp(mem_rsp)
	);

	bus_status_regs u_bus_status_regs (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(status_request),
		.i_cmd(target_cmd),
		.o_rsp(status_rsp),
		.i_event(bus_event),
		.o_fault(o_fault)
	);

endmodule

/* hdl/bus_status_regs.sv */
// ============================================================
// Bus status registers
// ============================================================

`timescale 1ns/1ns

module bus_status_regs import bus_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_request,
	input bus_req_t i_cmd,
	output bus_rsp_t o_rsp,
	input bus_event_t i_event,
	output logic o_fault
);

	bus_data_t read_count;
	bus_data_t write_count;
	bus_data_t scratch;
	logic fault_flag;
	logic ready_q;
	bus_data_t rdata_q;
	logic [3:0] offset;

	// Word offset within the block
	assign offset = {i_cmd.address[3:2], 2'b00};

	// ============================================================
	// Counters, scratch and sticky fault
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			read_count <= '0;
			write_count <= '0;
			scratch <= '0;
			fault_flag <= 1'b0;
			ready_q <= 1'b0;
		end else begin
			ready_q <= i_request;
			if (i_event.done) begin
				if (i_event.rw)
					write_count <= write_count + 1'b1;
				else
					read_count <= read_count + 1'b1;
				if (i_event.fault)
					fault_flag <= 1'b1;
			end
			// Counters are read only
			if (i_request && i_cmd.rw) begin
				if (offset == STATUS_SCRATCH[3:0])
					scratch <= i_cmd.wdata;
				if (offset == STATUS_FAULT[3:0] && i_cmd.wdata[0])
					fault_flag <= 1'b0;
			end
		end
	end

	// Read mux, sampled before this access is counted
	always_ff @(posedge i_clock) begin
		if (i_request) begin
			case (offset)
				STATUS_READS[3:0]: rdata_q <= read_count;
				STATUS_WRITES[3:0]: rdata_q <= write_count;
				STATUS_SCRATCH[3:0]: rdata_q <= scratch;
				default: rdata_q <= {31'b0, fault_flag};
			endcase
		end
	end

	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = rdata_q;
	assign o_fault = fault_flag;

endmodule

/* hdl/bus_memory.sv */
// ============================================================
// Word-addressed bus RAM
// ============================================================

`timescale 1ns/1ns

module bus_memory import bus_pkg::*; (
	input logic i_clock,
	input logic i_request,
	input bus_req_t i_cmd,
	output bus_rsp_t o_rsp
);

	bus_data_t mem [MEM_WORDS];
	mem_index_t index;

	// Decoder only strobes for in-range addresses
	assign index = i_cmd.address[2 +: MEM_INDEX_W];

	// Power-up contents
	initial begin
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = '0;
	end

	// ============================================================
	// Single port, reply one cycle after the strobe
	always_ff @(posedge i_clock) begin
		o_rsp.ready <= i_request;
		if (i_request) begin
			if (i_cmd.rw) begin
				mem[index] <= i_cmd.wdata;
				// Write echoes the stored word
				o_rsp.rdata <= i_cmd.wdata;
			end else begin
				o_rsp.rdata <= mem[index];
			end
		end
	end

endmodule

/* hdl/bus_decoder.sv */
// ============================================================
// Bus address decoder
// ============================================================

`timescale 1ns/1ns

module bus_decoder import bus_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	// From the multiplexer
	input logic i_bus_request,
	input bus_req_t i_bus_cmd,
	output bus_rsp_t o_bus_rsp,

	// To the targets
	output logic o_mem_request,
	output logic o_status_request,
	output bus_req_t o_cmd,
	input bus_rsp_t i_mem_rsp,
	input bus_rsp_t i_status_rsp,

	// Completion report
	output bus_event_t o_event
);

	logic hit_mem;
	logic hit_status;
	logic mem_sel_q;
	logic status_sel_q;
	logic fault_q;
	logic rw_q;

	// Region from the top nibble, RAM also range checked
	assign hit_mem = (i_bus_cmd.address[31:28] == MEM_BASE[31:28]) &&
		(i_bus_cmd.address[27:2] < 26'(MEM_WORDS));
	assign hit_status = (i_bus_cmd.address[31:28] == STATUS_BASE[31:28]);

	assign o_mem_request = i_bus_request && hit_mem;
	assign o_status_request = i_bus_request && hit_status;
	assign o_cmd = i_bus_cmd;

	// Remember target of the access in flight
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mem_sel_q <= 1'b0;
			status_sel_q <= 1'b0;
			fault_q <= 1'b0;
		end else begin
			fault_q <= i_bus_request && !hit_mem && !hit_status;
			if (i_bus_request) begin
				mem_sel_q <= hit_mem;
				status_sel_q <= hit_status;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_bus_request)
			rw_q <= i_bus_cmd.rw;
	end

	// Reply select, unmapped accesses answer with zero data
	always_comb begin
		o_bus_rsp = '0;
		if (mem_sel_q)
			o_bus_rsp = i_mem_rsp;
		else if (status_sel_q)
			o_bus_rsp = i_status_rsp;
		else
			o_bus_rsp.ready = fault_q;
	end

	assign o_event.done = o_bus_rsp.ready;
	assign o_event.rw = rw_q;
	assign o_event.fault = fault_q;

endmodule

/* hdl/bus_mux.sv */
// ============================================================
// Registered two-port bus multiplexer
// ============================================================

`timescale 1ns/1ns

module bus_mux import bus_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	// Port A, instruction side, read only
	input logic i_pa_request,
	input bus_addr_t i_pa_address,
	output logic o_pa_ready,
	output bus_data_t o_pa_rdata,

	// Port B, data side
	input logic i_pb_request,
	input bus_req_t i_pb_cmd,
	output logic o_pb_ready,
	output bus_data_t o_pb_rdata,

	// Shared bus
	output logic o_bus_request,
	output bus_req_t o_bus_cmd,
	input bus_rsp_t i_bus_rsp
);

	mux_state_t state;
	logic owner_b;
	logic pick_a;
	logic pick_b;
	bus_data_t rdata_q;

	// ============================================================
	// Arbitration
	// B wins in IDLE. While the owner sees its ready its request is
	// still the old one, so only the other port may start then.
	always_comb begin
		pick_a = 1'b0;
		pick_b = 1'b0;
		case (state)
			IDLE: begin
				pick_b = i_pb_request;
				pick_a = i_pa_request && !i_pb_request;
			end
			REPLY: begin
				if (owner_b)
					pick_a = i_pa_request;
				else
					pick_b = i_pb_request;
			end
			default: begin
				pick_a = 1'b0;
				pick_b = 1'b0;
			end
		endcase
	end

	// ============================================================
	// Control FSM
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
			owner_b <= 1'b0;
			o_bus_request <= 1'b0;
			o_pa_ready <= 1'b0;
			o_pb_ready <= 1'b0;
		end else begin
			o_bus_request <= 1'b0;
			o_pa_ready <= 1'b0;
			o_pb_ready <= 1'b0;
			case (state)
				IDLE, REPLY: begin
					state <= IDLE;
					if (pick_a || pick_b) begin
						state <= BUSY;
						owner_b <= pick_b;
						o_bus_request <= 1'b1;
					end
				end
				BUSY: begin
					// Reply always comes one cycle after the strobe
					if (i_bus_rsp.ready) begin
						state <= REPLY;
						o_pa_ready <= !owner_b;
						o_pb_ready <= owner_b;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Latched command and returned data
	always_ff @(posedge i_clock) begin
		if (pick_b) begin
			o_bus_cmd <= i_pb_cmd;
		end else if (pick_a) begin
			o_bus_cmd.rw <= 1'b0;
			o_bus_cmd.address <= i_pa_address;
			o_bus_cmd.wdata <= '0;
		end
		if (state == BUSY && i_bus_rsp.ready)
			rdata_q <= i_bus_rsp.rdata;
	end

	assign o_pa_rdata = rdata_q;
	assign o_pb_rdata = rdata_q;

endmodule

/* hdl/bus_pkg.sv */
// ============================================================
// Shared bus types and address map
// ============================================================

package bus_pkg;

	// ============================================================
	// Widths
	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	// RAM geometry
	localparam int MEM_WORDS = 256;
	localparam int MEM_INDEX_W = $clog2(MEM_WORDS);
	typedef logic [MEM_INDEX_W-1:0] mem_index_t;

	// ============================================================
	// Address map, region is picked by bits 31:28
	localparam bus_addr_t MEM_BASE = 32'h0000_0000;
	localparam bus_addr_t STATUS_BASE = 32'h1000_0000;

	// Status register offsets
	localparam bus_addr_t STATUS_READS = 32'h0;
	localparam bus_addr_t STATUS_WRITES = 32'h4;
	localparam bus_addr_t STATUS_SCRATCH = 32'h8;
	localparam bus_addr_t STATUS_FAULT = 32'hC;

	// ============================================================
	// Bus structs
	typedef struct packed {
		logic rw;
		bus_addr_t address;
		bus_data_t wdata;
	} bus_req_t;

	typedef struct packed {
		logic ready;
		bus_data_t rdata;
	} bus_rsp_t;

	// One-cycle completion report
	typedef struct packed {
		logic done;
		logic rw;
		logic fault;
	} bus_event_t;

	typedef enum logic [1:0] {IDLE, BUSY, REPLY} mux_state_t;

endpackage
